/* logic/video_pkg.sv */
// Shared display timing, memory widths and renderer state for the tile renderer modules
package video_pkg;

  // 640x480 frame, counted in pixel clocks and lines
  localparam int H_TOTAL   = 800;
  localparam int V_TOTAL   = 525;
  localparam int H_VISIBLE = 640;
  localparam int V_VISIBLE = 480;

  // Horizontal sync window, active high
  localparam int H_SYNC_START = 656;
  localparam int H_SYNC_END   = 751;

  // Vertical sync window before the two-line scanout delay
  localparam int V_SYNC_START = 490;
  localparam int V_SYNC_END   = 491;

  // Pixels drawn per screen row at half resolution
  localparam int LINE_PIXELS = 320;
  localparam int NUM_LAYERS  = 2;

  // Screen counter width
  localparam int POS_WIDTH = 10;

  // Tilemap address is {layer, map row, map column}
  localparam int MAP_ADDR_WIDTH = 11;
  // Tilemap entry is the tile number only
  localparam int MAP_DATA_WIDTH = 8;

  // Two 8-bit palette indexes per VRAM word
  localparam int VRAM_DATA_WIDTH = 16;
  localparam int PAL_ADDR_WIDTH  = 8;

  // Red low byte, green middle byte, blue high byte
  localparam int COLOR_WIDTH = 24;

  // Half-select bit followed by the 9-bit x position
  localparam int LBUF_ADDR_WIDTH = 10;

  typedef enum logic [1:0] {
    RENDER_IDLE,
    RENDER_DECIDE,
    RENDER_DRAW
  } render_state_t;

endpackage

/* logic/display_timing.sv */
// Frame position counter that decodes sync, blanking and visible position for the renderer
`timescale 1ns/1ps

module display_timing
  import video_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  output logic [POS_WIDTH-1:0] h_pos,
  output logic [POS_WIDTH-1:0] v_pos,
  output logic [POS_WIDTH-1:0] x_vis,
  output logic [POS_WIDTH-1:0] y_vis,
  output logic                 h_blank,
  output logic                 v_blank,
  output logic                 h_sync,
  output logic                 v_sync_late
);

  logic h_wrap;
  logic v_wrap;

  // End of line and end of frame
  assign h_wrap = (h_pos == POS_WIDTH'(H_TOTAL - 1));
  assign v_wrap = (v_pos == POS_WIDTH'(V_TOTAL - 1));

  // Pixel counter, steps every clock
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      h_pos <= '0;
    end else if (h_wrap) begin
      h_pos <= '0;
    end else begin
      h_pos <= h_pos + 1'b1;
    end
  end

  // Line counter, steps on each horizontal wrap
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      v_pos <= '0;
    end else if (h_wrap) begin
      if (v_wrap) begin
        v_pos <= '0;
      end else begin
        v_pos <= v_pos + 1'b1;
      end
    end
  end

  // Blanking outside the 640x480 window
  assign h_blank = (h_pos >= POS_WIDTH'(H_VISIBLE));
  assign v_blank = (v_pos >= POS_WIDTH'(V_VISIBLE));

  // Visible position, held at 0 while blanked
  assign x_vis = h_blank ? '0 : h_pos;
  assign y_vis = v_blank ? '0 : v_pos;

  assign h_sync = (h_pos >= POS_WIDTH'(H_SYNC_START)) && (h_pos <= POS_WIDTH'(H_SYNC_END));

  // Sync window moved down two lines to match the line buffer latency
  assign v_sync_late = (v_pos >= POS_WIDTH'(V_SYNC_START + 2)) &&
                       (v_pos <= POS_WIDTH'(V_SYNC_END + 2));

endmodule

/* logic/line_renderer.sv */
// Layer sequencer and fetch pipeline that draws one screen row of tiles into the line buffer
`timescale 1ns/1ps

module line_renderer
  import video_pkg::*;
#(
  parameter int VRAM_ADDR_WIDTH = 15
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [POS_WIDTH-1:0]       h_pos,
  input  logic [POS_WIDTH-1:0]       y_vis,
  input  logic                       v_blank,
  input  logic [NUM_LAYERS-1:0]      layer_en,
  input  logic [8:0]                 scroll_x0,
  input  logic [8:0]                 scroll_y0,
  input  logic [8:0]                 scroll_x1,
  input  logic [8:0]                 scroll_y1,
  output logic [MAP_ADDR_WIDTH-1:0]  map_addr,
  input  logic [MAP_DATA_WIDTH-1:0]  map_data,
  output logic [VRAM_ADDR_WIDTH-1:0] vram_addr,
  input  logic [VRAM_DATA_WIDTH-1:0] vram_data,
  output logic [PAL_ADDR_WIDTH-1:0]  pal_addr,
  input  logic [COLOR_WIDTH-1:0]     pal_data,
  output logic                       lbuf_wr,
  output logic [LBUF_ADDR_WIDTH-1:0] lbuf_waddr,
  output logic [COLOR_WIDTH-1:0]     lbuf_wdata
);

  // Row and column width in half-resolution pixels
  localparam int RX_WIDTH = LBUF_ADDR_WIDTH - 1;

  render_state_t               state;
  logic                        layer;
  logic [RX_WIDTH-1:0]         render_x;
  logic [RX_WIDTH-1:0]         render_row;
  logic                        line_end;
  logic [RX_WIDTH-1:0]         scroll_x;
  logic [RX_WIDTH-1:0]         scroll_y;
  logic [RX_WIDTH-1:0]         world_x;
  logic [RX_WIDTH-1:0]         world_y;
  logic [PAL_ADDR_WIDTH-1:0]   pix_index;

  // Fetch stage 1, VRAM and palette address
  logic                        s1_valid;
  logic                        s1_layer;
  logic [3:0]                  s1_fine_x;
  logic [3:0]                  s1_fine_y;
  logic [LBUF_ADDR_WIDTH-1:0]  s1_waddr;

  // Fetch stage 2, line buffer write
  logic                        s2_valid;
  logic                        s2_transparent;
  logic [LBUF_ADDR_WIDTH-1:0]  s2_waddr;

  // Last clock of the second display line of the pair
  assign line_end = (h_pos == POS_WIDTH'(H_TOTAL - 1)) && y_vis[0];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= RENDER_IDLE;
      layer      <= 1'b0;
      render_x   <= '0;
      render_row <= '0;
    end else begin
      case (state)
        RENDER_IDLE: begin
          // Start on the first clock of an even visible line
          if (h_pos == '0 && !v_blank && !y_vis[0]) begin
            state      <= RENDER_DECIDE;
            layer      <= 1'b0;
            render_row <= y_vis[POS_WIDTH-1:1];
          end
        end
        RENDER_DECIDE: begin
          render_x <= '0;
          if (line_end) begin
            state <= RENDER_IDLE;
          end else if (layer && !layer_en[1]) begin
            // Disabled layer 1 is skipped entirely
            state <= RENDER_IDLE;
          end else begin
            // Layer 0 always runs, a disabled one paints the backdrop
            state <= RENDER_DRAW;
          end
        end
        RENDER_DRAW: begin
          if (line_end) begin
            // Out of time, drop the rest of the row
            state <= RENDER_IDLE;
          end else if (render_x == RX_WIDTH'(LINE_PIXELS - 1)) begin
            if (layer) begin
              state <= RENDER_IDLE;
            end else begin
              layer <= 1'b1;
              state <= RENDER_DECIDE;
            end
          end else begin
            render_x <= render_x + 1'b1;
          end
        end
        default: state <= RENDER_IDLE;
      endcase
    end
  end

  // Per-layer scroll, world position wraps at 512
  assign scroll_x = layer ? scroll_x1 : scroll_x0;
  assign scroll_y = layer ? scroll_y1 : scroll_y0;
  assign world_x  = render_x + scroll_x;
  assign world_y  = render_row + scroll_y;

  // Screen position -> tilemap entry, data returns next clock
  assign map_addr = {layer, world_y[RX_WIDTH-1:4], world_x[RX_WIDTH-1:4]};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= (state == RENDER_DRAW);
    end
  end

  // Fine position and target follow the tilemap read
  always_ff @(posedge clk) begin
    s1_layer  <= layer;
    s1_fine_x <= world_x[3:0];
    s1_fine_y <= world_y[3:0];
    s1_waddr  <= {render_row[0], render_x};
  end

  // Tile number -> VRAM word, read combinationally
  assign vram_addr = VRAM_ADDR_WIDTH'({map_data, s1_fine_y, s1_fine_x[3:1]});

  // Even pixel in the low byte, odd pixel in the high byte
  assign pix_index = s1_fine_x[0] ? vram_data[VRAM_DATA_WIDTH-1 -: PAL_ADDR_WIDTH]
                                  : vram_data[PAL_ADDR_WIDTH-1:0];

  // Disabled layer 0 forces palette entry 0
  assign pal_addr = (!s1_layer && !layer_en[0]) ? '0 : pix_index;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      s2_valid       <= 1'b0;
      s2_transparent <= 1'b0;
    end else begin
      s2_valid       <= s1_valid;
      // Index 0 in layer 1 lets layer 0 show through
      s2_transparent <= s1_layer && (pal_addr == '0);
    end
  end

  always_ff @(posedge clk) begin
    s2_waddr <= s1_waddr;
  end

  // Palette color lands in the line buffer two clocks after the fetch
  assign lbuf_wr    = s2_valid && !s2_transparent;
  assign lbuf_waddr = s2_waddr;
  assign lbuf_wdata = pal_data;

endmodule

/* logic/line_buffer.sv */
// Double line buffer RAM, one half drawn by the renderer while the other is scanned out
`timescale 1ns/1ps

module line_buffer
  import video_pkg::*;
(
  input  logic                       clk,
  input  logic                       wr,
  input  logic [LBUF_ADDR_WIDTH-1:0] waddr,
  input  logic [COLOR_WIDTH-1:0]     wdata,
  input  logic                       rd,
  input  logic [LBUF_ADDR_WIDTH-1:0] raddr,
  output logic [COLOR_WIDTH-1:0]     rdata
);

  // Two rows of 512 entries, upper address bit picks the half
  logic [COLOR_WIDTH-1:0] mem [0:(1 << LBUF_ADDR_WIDTH)-1];

  // Renderer write port
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[waddr] <= wdata;
    end
  end

  // Scanout read port, output holds while rd is low
  always_ff @(posedge clk) begin
    if (rd) begin
      rdata <= mem[raddr];
    end
  end

endmodule

/* logic/pixel_scanout.sv */
// Reads the finished row back from the line buffer and drives doubled pixels and h_sync
`timescale 1ns/1ps

module pixel_scanout
  import video_pkg::*;
#(
  parameter int RGB_DEPTH = 18
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [POS_WIDTH-1:0]       x_vis,
  input  logic [POS_WIDTH-1:0]       y_vis,
  input  logic                       h_blank,
  input  logic                       v_blank,
  input  logic                       h_sync,
  output logic                       lbuf_rd,
  output logic [LBUF_ADDR_WIDTH-1:0] lbuf_raddr,
  input  logic [COLOR_WIDTH-1:0]     lbuf_rdata,
  output logic                       h_sync_out,
  output logic [RGB_DEPTH-1:0]       rgb_out
);

  // Output bits per channel, and stored bits per channel
  localparam int CH_OUT = RGB_DEPTH / 3;
  localparam int CH_IN  = COLOR_WIDTH / 3;

  logic [1:0] h_sync_q;
  logic       blank_q;

  // Read only inside the visible window
  assign lbuf_rd = !(h_blank || v_blank);

  // Previous row sits in the half opposite the one being drawn
  // Dropping x bit 0 doubles each pixel across two clocks
  assign lbuf_raddr = {~y_vis[1], x_vis[POS_WIDTH-1:1]};

  // Sync takes two clocks, buffer read plus output register
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      h_sync_q <= '0;
    end else begin
      h_sync_q <= {h_sync_q[0], h_sync};
    end
  end

  assign h_sync_out = h_sync_q[1];

  // First blanking stage lines up with the read data
  // The rgb_out register below is the second
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      blank_q <= 1'b1;
    end else begin
      blank_q <= h_blank || v_blank;
    end
  end

  // Top bits of each channel, blue high and red low
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rgb_out <= '0;
    end else if (blank_q) begin
      rgb_out <= '0;
    end else begin
      rgb_out <= {lbuf_rdata[3*CH_IN-1 -: CH_OUT],
                  lbuf_rdata[2*CH_IN-1 -: CH_OUT],
                  lbuf_rdata[CH_IN-1 -: CH_OUT]};
    end
  end

endmodule

/* logic/tile_renderer_top.sv */
// Tile renderer top level joining timing, line renderer, line buffer and scanout
`timescale 1ns/1ps

module tile_renderer_top
  import video_pkg::*;
#(
  parameter int VRAM_ADDR_WIDTH = 15,
  parameter int RGB_DEPTH       = 18
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [NUM_LAYERS-1:0]      layer_en,
  input  logic [8:0]                 scroll_x0,
  input  logic [8:0]                 scroll_y0,
  input  logic [8:0]                 scroll_x1,
  input  logic [8:0]                 scroll_y1,
  output logic [MAP_ADDR_WIDTH-1:0]  map_addr,
  input  logic [MAP_DATA_WIDTH-1:0]  map_data,
  output logic [VRAM_ADDR_WIDTH-1:0] vram_addr,
  input  logic [VRAM_DATA_WIDTH-1:0] vram_data,
  output logic [PAL_ADDR_WIDTH-1:0]  pal_addr,
  input  logic [COLOR_WIDTH-1:0]     pal_data,
  output logic                       h_sync,
  output logic                       v_sync,
  output logic [RGB_DEPTH-1:0]       rgb_out
);

  // Frame position and decoded timing
  logic [POS_WIDTH-1:0]       h_pos;
  logic [POS_WIDTH-1:0]       x_vis;
  logic [POS_WIDTH-1:0]       y_vis;
  logic                       h_blank;
  logic                       v_blank;
  logic                       h_sync_raw;

  // Renderer write side of the line buffer
  logic                       lbuf_wr;
  logic [LBUF_ADDR_WIDTH-1:0] lbuf_waddr;
  logic [COLOR_WIDTH-1:0]     lbuf_wdata;

  // Scanout read side of the line buffer
  logic                       lbuf_rd;
  logic [LBUF_ADDR_WIDTH-1:0] lbuf_raddr;
  logic [COLOR_WIDTH-1:0]     lbuf_rdata;

  // v_sync leaves already shifted by two lines
  display_timing timing_i (
    .clk         (clk),
    .reset       (reset),
    .h_pos       (h_pos),
    .v_pos       (),
    .x_vis       (x_vis),
    .y_vis       (y_vis),
    .h_blank     (h_blank),
    .v_blank     (v_blank),
    .h_sync      (h_sync_raw),
    .v_sync_late (v_sync)
  );

  line_renderer #(
    .VRAM_ADDR_WIDTH (VRAM_ADDR_WIDTH)
  ) renderer_i (
    .clk        (clk),
    .reset      (reset),
    .h_pos      (h_pos),
    .y_vis      (y_vis),
    .v_blank    (v_blank),
    .layer_en   (layer_en),
    .scroll_x0  (scroll_x0),
    .scroll_y0  (scroll_y0),
    .scroll_x1  (scroll_x1),
    .scroll_y1  (scroll_y1),
    .map_addr   (map_addr),
    .map_data   (map_data),
    .vram_addr  (vram_addr),
    .vram_data  (vram_data),
    .pal_addr   (pal_addr),
    .pal_data   (pal_data),
    .lbuf_wr    (lbuf_wr),
    .lbuf_waddr (lbuf_waddr),
    .lbuf_wdata (lbuf_wdata)
  );

  line_buffer lbuf_i (
    .clk   (clk),
    .wr    (lbuf_wr),
    .waddr (lbuf_waddr),
    .wdata (lbuf_wdata),
    .rd    (lbuf_rd),
    .raddr (lbuf_raddr),
    .rdata (lbuf_rdata)
  );

  pixel_scanout #(
    .RGB_DEPTH (RGB_DEPTH)
  ) scanout_i (
    .clk        (clk),
    .reset      (reset),
    .x_vis      (x_vis),
    .y_vis      (y_vis),
    .h_blank    (h_blank),
    .v_blank    (v_blank),
    .h_sync     (h_sync_raw),
    .lbuf_rd    (lbuf_rd),
    .lbuf_raddr (lbuf_raddr),
    .lbuf_rdata (lbuf_rdata),
    .h_sync_out (h_sync),
    .rgb_out    (rgb_out)
  );

endmodule

/* tb/tile_renderer_ref.sv */
// Reference model holding the tilemap, VRAM and palette images and the expected output rules
`timescale 1ns/1ps

module tile_renderer_ref
  import video_pkg::*;
#(
  parameter int VRAM_ADDR_WIDTH = 15,
  parameter int RGB_DEPTH       = 18
);

  // Output bits per channel
  localparam int CH = RGB_DEPTH / 3;

  // Model memories, also served to the DUT by the testbench
  logic [MAP_DATA_WIDTH-1:0]  map_mem  [0:(1 << MAP_ADDR_WIDTH)-1];
  logic [VRAM_DATA_WIDTH-1:0] vram_mem [0:(1 << VRAM_ADDR_WIDTH)-1];
  logic [COLOR_WIDTH-1:0]     pal_mem  [0:(1 << PAL_ADDR_WIDTH)-1];

  // Palette index of one layer at a screen row and column
  function automatic int layer_index(input int layer, input int row, input int col,
                                     input int sx, input int sy);
    int wx;
    int wy;
    int tile;
    int word;
    // World position wraps at 512
    wx = (col + sx) % 512;
    wy = (row + sy) % 512;
    // 32x32 map per layer, 16x16 tiles
    tile = map_mem[layer * 1024 + (wy / 16) * 32 + wx / 16];
    // 8 words per tile row, two pixels per word
    word = vram_mem[tile * 128 + (wy % 16) * 8 + (wx % 16) / 2];
    return (wx % 2 == 1) ? (word >> 8) & 8'hff : word & 8'hff;
  endfunction

  // Color of a screen pixel, layer 1 over layer 0
  function automatic logic [COLOR_WIDTH-1:0] expected_color(input int row, input int col,
      input logic [1:0] en, input int sx0, input int sy0, input int sx1, input int sy1);
    int idx0;
    int idx1;
    logic [COLOR_WIDTH-1:0] color;
    // Disabled layer 0 shows the backdrop entry
    idx0 = en[0] ? layer_index(0, row, col, sx0, sy0) : 0;
    color = pal_mem[idx0];
    if (en[1]) begin
      idx1 = layer_index(1, row, col, sx1, sy1);
      // Index 0 is see-through
      if (idx1 != 0) begin
        color = pal_mem[idx1];
      end
    end
    return color;
  endfunction

  // Top bits of blue, green, red with red in the low part
  function automatic logic [RGB_DEPTH-1:0] pack_rgb(input logic [COLOR_WIDTH-1:0] c);
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    red   = c[7:0];
    green = c[15:8];
    blue  = c[23:16];
    return {blue[7 -: CH], green[7 -: CH], red[7 -: CH]};
  endfunction

  // h_sync window after the two-clock scanout delay
  function automatic logic h_sync_level(input int h);
    return (h >= H_SYNC_START + 2) && (h <= H_SYNC_END + 2);
  endfunction

  // v_sync window after the two-line delay
  function automatic logic v_sync_level(input int v);
    return (v >= V_SYNC_START + 2) && (v <= V_SYNC_END + 2);
  endfunction

endmodule

/* tb/tile_renderer_tb.sv */
// Testbench that runs directed frame checks of the tile renderer against the reference model
`timescale 1ns/1ps

module tile_renderer_tb
  import video_pkg::*;
();

  localparam int VRAM_ADDR_WIDTH = 15;
  localparam int RGB_DEPTH       = 18;
  localparam int CLK_PERIOD      = 40;
  localparam int NUM_TESTS       = 5;
  localparam longint FRAME_NS    = longint'(H_TOTAL) * V_TOTAL * CLK_PERIOD;
  // Four frames per test plus one frame of margin
  localparam longint WATCHDOG_NS = NUM_TESTS * 4 * FRAME_NS + FRAME_NS;

  logic                       clk = 1'b0;
  logic                       reset;
  logic [NUM_LAYERS-1:0]      layer_en;
  logic [8:0]                 scroll_x0;
  logic [8:0]                 scroll_y0;
  logic [8:0]                 scroll_x1;
  logic [8:0]                 scroll_y1;
  logic [MAP_ADDR_WIDTH-1:0]  map_addr;
  logic [MAP_DATA_WIDTH-1:0]  map_data = '0;
  logic [VRAM_ADDR_WIDTH-1:0] vram_addr;
  logic [VRAM_DATA_WIDTH-1:0] vram_data;
  logic [PAL_ADDR_WIDTH-1:0]  pal_addr;
  logic [COLOR_WIDTH-1:0]     pal_data = '0;
  logic                       h_sync;
  logic                       v_sync;
  logic [RGB_DEPTH-1:0]       rgb_out;

  // Frame position seen by the testbench
  int cnt_h;
  int cnt_v;

  always #(CLK_PERIOD / 2) clk = ~clk;

  tile_renderer_top #(
    .VRAM_ADDR_WIDTH (VRAM_ADDR_WIDTH),
    .RGB_DEPTH       (RGB_DEPTH)
  ) dut_i (
    .clk       (clk),
    .reset     (reset),
    .layer_en  (layer_en),
    .scroll_x0 (scroll_x0),
    .scroll_y0 (scroll_y0),
    .scroll_x1 (scroll_x1),
    .scroll_y1 (scroll_y1),
    .map_addr  (map_addr),
    .map_data  (map_data),
    .vram_addr (vram_addr),
    .vram_data (vram_data),
    .pal_addr  (pal_addr),
    .pal_data  (pal_data),
    .h_sync    (h_sync),
    .v_sync    (v_sync),
    .rgb_out   (rgb_out)
  );

  tile_renderer_ref #(
    .VRAM_ADDR_WIDTH (VRAM_ADDR_WIDTH),
    .RGB_DEPTH       (RGB_DEPTH)
  ) ref_i ();

  // Tilemap and palette answer one clock after the address
  always @(posedge clk) begin
    map_data <= #2 ref_i.map_mem[map_addr];
    pal_data <= #2 ref_i.pal_mem[pal_addr];
  end

  // VRAM reads are combinational
  assign vram_data = ref_i.vram_mem[vram_addr];

  // 800x525 position that starts at 0,0 in the first clock after reset
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      cnt_h <= 0;
      cnt_v <= 0;
    end else if (cnt_h == H_TOTAL - 1) begin
      cnt_h <= 0;
      cnt_v <= (cnt_v == V_TOTAL - 1) ? 0 : cnt_v + 1;
    end else begin
      cnt_h <= cnt_h + 1;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_rgb(input string name, input int h, input int v,
                           input logic [RGB_DEPTH-1:0] expected,
                           input logic [RGB_DEPTH-1:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: rgb_out at (%0d,%0d) expected %h actual %h",
               name, h, v, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_sync(input string name, input string signal, input int h, input int v,
                            input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR %s: %s at (%0d,%0d) expected %b actual %b",
               name, signal, h, v, expected, actual);
      abort_run();
    end
  endtask

  // Inputs change and outputs are read 2 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic fill_memories();
    logic [31:0] rnd;
    logic [7:0]  lo;
    logic [7:0]  hi;
    rnd = 32'h1ea4_9b14;
    for (int i = 0; i < (1 << MAP_ADDR_WIDTH); i++) begin
      rnd = xorshift32(rnd);
      ref_i.map_mem[i] = rnd[7:0];
    end
    // About a quarter of the indexes are 0 so layer 1 has holes
    for (int i = 0; i < (1 << VRAM_ADDR_WIDTH); i++) begin
      rnd = xorshift32(rnd);
      lo = (rnd[1:0] == 2'd0) ? 8'd0 : rnd[15:8];
      hi = (rnd[3:2] == 2'd0) ? 8'd0 : rnd[23:16];
      ref_i.vram_mem[i] = {hi, lo};
    end
    for (int i = 0; i < (1 << PAL_ADDR_WIDTH); i++) begin
      rnd = xorshift32(rnd);
      ref_i.pal_mem[i] = rnd[23:0];
    end
  endtask

  task automatic wait_frame_start();
    while (!(cnt_h == 0 && cnt_v == 0)) begin
      next_cycle();
    end
  endtask

  // Output at the current clock belongs to the position two clocks back
  task automatic check_frame(input string name, input bit pixels, input int lines);
    int hd;
    int vd;
    logic [RGB_DEPTH-1:0] expected;
    wait_frame_start();
    repeat (H_TOTAL * lines) begin
      if (cnt_h >= 2) begin
        hd = cnt_h - 2;
        vd = cnt_v;
      end else begin
        hd = cnt_h + H_TOTAL - 2;
        vd = (cnt_v == 0) ? V_TOTAL - 1 : cnt_v - 1;
      end
      if (hd >= H_VISIBLE || vd >= V_VISIBLE) begin
        check_rgb(name, hd, vd, '0, rgb_out);
      end else if (pixels && vd >= 2) begin
        // Line pair v shows row v/2-1 with each pixel doubled
        expected = ref_i.pack_rgb(ref_i.expected_color(vd / 2 - 1, hd / 2, layer_en,
                   scroll_x0, scroll_y0, scroll_x1, scroll_y1));
        check_rgb(name, hd, vd, expected, rgb_out);
      end
      check_sync(name, "h_sync", cnt_h, cnt_v, ref_i.h_sync_level(cnt_h), h_sync);
      check_sync(name, "v_sync", cnt_h, cnt_v, ref_i.v_sync_level(cnt_v), v_sync);
      next_cycle();
    end
  endtask

  // New settings land in vertical blanking before the next frame is checked
  task automatic run_config(input string name, input logic [1:0] en,
                            input logic [8:0] sx0, input logic [8:0] sy0,
                            input logic [8:0] sx1, input logic [8:0] sy1);
    while (cnt_v < V_VISIBLE) begin
      next_cycle();
    end
    layer_en  = en;
    scroll_x0 = sx0;
    scroll_y0 = sy0;
    scroll_x1 = sx1;
    scroll_y1 = sy1;
    // Stop one line past the last visible line
    check_frame(name, 1'b1, V_VISIBLE + 1);
  endtask

  task automatic test_reset();
    repeat (8) begin
      next_cycle();
      check_rgb("test_reset", cnt_h, cnt_v, '0, rgb_out);
      check_sync("test_reset", "h_sync", cnt_h, cnt_v, 1'b0, h_sync);
      check_sync("test_reset", "v_sync", cnt_h, cnt_v, 1'b0, v_sync);
    end
    reset = 1'b0;
    // The first pixel reaches rgb_out two clocks after reset is released
    repeat (2) begin
      check_rgb("test_reset", cnt_h, cnt_v, '0, rgb_out);
      check_sync("test_reset", "h_sync", cnt_h, cnt_v, 1'b0, h_sync);
      check_sync("test_reset", "v_sync", cnt_h, cnt_v, 1'b0, v_sync);
      next_cycle();
    end
  endtask

  task automatic test_sync();
    check_frame("test_sync", 1'b0, V_TOTAL);
  endtask

  task automatic test_layer0();
    run_config("test_layer0", 2'b01, 9'd0, 9'd0, 9'd0, 9'd0);
  endtask

  task automatic test_scroll();
    run_config("test_scroll", 2'b01, 9'd37, 9'd5, 9'd0, 9'd0);
    // Both axes wrap past 511 inside the row
    run_config("test_scroll", 2'b01, 9'd499, 9'd381, 9'd0, 9'd0);
  endtask

  task automatic test_layers();
    run_config("test_layers", 2'b11, 9'd3, 9'd250, 9'd300, 9'd17);
    // Holes in layer 1 show the backdrop entry
    run_config("test_layers", 2'b10, 9'd0, 9'd0, 9'd450, 9'd400);
  endtask

  initial begin
    reset     = 1'b1;
    layer_en  = 2'b01;
    scroll_x0 = '0;
    scroll_y0 = '0;
    scroll_x1 = '0;
    scroll_y1 = '0;
    fill_memories();
    test_reset();
    test_sync();
    test_layer0();
    test_scroll();
    test_layers();
    $display("Finished with no errors");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not complete in the allowed simulation time");
    abort_run();
  end

endmodule

/* project.f */
logic/video_pkg.sv
logic/display_timing.sv
logic/line_renderer.sv
logic/line_buffer.sv
logic/pixel_scanout.sv
logic/tile_renderer_top.sv
tb/tile_renderer_ref.sv
tb/tile_renderer_tb.sv
